/* all.f */
+incdir+hdl
hdl/kl_ebus_pkg.sv
hdl/diag_if.sv
hdl/diag_decoder.sv
hdl/edp_slice.sv
hdl/ebus_mux.sv
hdl/kl_ebus_top.sv
bench/tb_kl_ebus.sv

/* bench/tb_kl_ebus.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kl_ebus_cfg.svh"

module tb_kl_ebus;

  localparam int RESET_CYCLES  = 2;
  localparam int IDLE_CYCLES   = 4;
  localparam int NUM_TESTS     = 6;
  localparam int DRAIN_CYCLES  = 4;
  localparam int INC_CASES     = 43;
  localparam int BAD_CASES     = 20;
  localparam int TOTAL_STROBES = 2 + 400 + INC_CASES * 3 + 150 + 200 + BAD_CASES * 3;
  localparam int LIMIT = TOTAL_STROBES + RESET_CYCLES + IDLE_CYCLES
                         + NUM_TESTS * DRAIN_CYCLES + 20;

  logic                     clk;
  logic                     rst_n;
  logic                     diag_strobe;
  logic [`KL_DS_BITS-1:0]   ds;
  logic [`KL_WORD_BITS-1:0] wdata;
  logic [`KL_WORD_BITS-1:0] rdata;
  logic                     rd_valid;

  logic [31:0]              rng;
  logic [`KL_WORD_BITS-1:0] model_ar;
  logic [`KL_WORD_BITS-1:0] model_ir;
  logic [`KL_WORD_BITS-1:0] last_read;
  logic [`KL_WORD_BITS-1:0] exp_data_q[$];
  int                       exp_cycle_q[$];
  int                       cycle;
  int                       errors;
  int                       tests;
  int                       errors_at_start;

  kl_ebus_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .diag_strobe (diag_strobe),
    .ds          (ds),
    .wdata       (wdata),
    .rdata       (rdata),
    .rd_valid    (rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [`KL_WORD_BITS-1:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi[3:0], lo};
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // One strobe per call, the model follows in issue order
  task automatic issue(input logic [2:0] code, input logic [`KL_WORD_BITS-1:0] data);
    @(posedge clk);
    #2;
    diag_strobe = 1'b1;
    ds          = code;
    wdata       = data;
    case (code)
      3'd0: model_ar = data;
      3'd1: begin
        exp_data_q.push_back(model_ar);
        exp_cycle_q.push_back(cycle + 2);
      end
      3'd2: model_ar = model_ar + 1'b1;
      3'd3: model_ir = data;
      3'd4: begin
        exp_data_q.push_back(model_ir);
        exp_cycle_q.push_back(cycle + 2);
      end
      default: ;
    endcase
  endtask

  task automatic drain();
    @(posedge clk);
    #2;
    diag_strobe = 1'b0;
    for (int i = 0; i < DRAIN_CYCLES && exp_data_q.size() != 0; i++) begin
      @(posedge clk);
    end
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("%0d reads were still outstanding at the end of the test",
               exp_data_q.size());
      exp_data_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name,
             (errors == errors_at_start) ? "ok" : "mismatches seen");
    errors_at_start = errors;
  endtask

  // Read returns are checked mid-cycle, away from the clock edge
  always @(negedge clk) begin : read_monitor
    logic [`KL_WORD_BITS-1:0] exp;
    int                       exp_cycle;
    if (rst_n && rd_valid) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("rd_valid was high at %0t with no read outstanding", $time);
      end else begin
        exp       = exp_data_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        check_value(rdata, exp, "read data");
        check_value(cycle, exp_cycle, "read return cycle");
        last_read = exp;
      end
    end else if (rst_n) begin
      check_value(rdata, last_read, "held rdata");
    end
  end

  initial begin : watchdog
    while (cycle < LIMIT) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not end within %0d cycles", LIMIT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [`KL_WORD_BITS-1:0] w;
    logic [31:0]              r;
    rst_n           = 1'b0;
    diag_strobe     = 1'b0;
    ds              = '0;
    wdata           = '0;
    rng             = 32'hc65f_8f12;
    model_ar        = '0;
    model_ir        = '0;
    last_read       = '0;
    cycle           = 0;
    errors          = 0;
    tests           = 0;
    errors_at_start = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clk);
      check_value(rd_valid, 1'b0, "idle rd_valid");
      check_value(rdata, '0, "idle rdata");
    end
    issue(3'd1, random_word());
    issue(3'd4, random_word());
    drain();
    end_test("reset state");

    for (int i = 0; i < 200; i++) begin
      issue(3'd0, random_word());
      issue(3'd1, random_word());
    end
    drain();
    end_test("AR write and read");

    // Wrap to zero, low slice full, and a full right half
    for (int i = 0; i < INC_CASES; i++) begin
      w = random_word();
      if (i == 0) begin
        w = '1;
      end else if (i == 1) begin
        w[5:0] = 6'o77;
      end else if (i == 2) begin
        w[17:0] = 18'o777777;
      end
      issue(3'd0, w);
      issue(3'd2, random_word());
      issue(3'd1, random_word());
    end
    drain();
    end_test("AR increment carry");

    for (int i = 0; i < 150; i++) begin
      r = next_random();
      case (r[1:0])
        2'd0: issue(3'd0, random_word());
        2'd1: issue(3'd1, random_word());
        2'd2: issue(3'd3, random_word());
        default: issue(3'd4, random_word());
      endcase
    end
    drain();
    end_test("IR and AR independence");

    for (int i = 0; i < 200; i++) begin
      r = next_random();
      issue(3'(r % 5), random_word());
    end
    drain();
    end_test("back-to-back strobes");

    for (int i = 0; i < BAD_CASES; i++) begin
      r = next_random();
      issue(3'd5 + 3'(r % 3), random_word());
      issue(3'd1, random_word());
      issue(3'd4, random_word());
    end
    drain();
    end_test("undefined codes");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/diag_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module diag_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    diag_strobe,
  input  kl_ebus_pkg::ds_e        ds,
  input  kl_ebus_pkg::ebus_word_u wdata,
  diag_if.decoder                 diag,
  output kl_ebus_pkg::ebus_word_u ir,
  output logic                    ir_driving
);

  logic ir_load;

  // Function decode, controls reach the slices one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diag.load    <= 1'b0;
      diag.inc     <= 1'b0;
      diag.read_ar <= 1'b0;
      ir_load      <= 1'b0;
      ir_driving   <= 1'b0;
    end else begin
      diag.load    <= diag_strobe && (ds == kl_ebus_pkg::DS_WR_AR);
      diag.inc     <= diag_strobe && (ds == kl_ebus_pkg::DS_INC_AR);
      diag.read_ar <= diag_strobe && (ds == kl_ebus_pkg::DS_RD_AR);
      ir_load      <= diag_strobe && (ds == kl_ebus_pkg::DS_WR_IR);
      ir_driving   <= diag_strobe && (ds == kl_ebus_pkg::DS_RD_IR);
    end
  end

  // Write data follows the strobe that carried it
  always_ff @(posedge clk) begin
    if (diag_strobe) begin
      diag.wdata <= wdata;
    end
  end

  // IR lives on this board, written in the same cycle AR would be
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= diag.wdata;
    end
  end

  // Undefined function codes are dropped without effect
  a_ds_defined: assert property (
    @(posedge clk) disable iff (!rst_n)
    diag_strobe |-> ds inside {kl_ebus_pkg::DS_WR_AR, kl_ebus_pkg::DS_RD_AR,
                               kl_ebus_pkg::DS_INC_AR, kl_ebus_pkg::DS_WR_IR,
                               kl_ebus_pkg::DS_RD_IR}
  ) else $warning("diag function code %0d is not defined and is ignored", ds);

endmodule

`default_nettype wire

/* hdl/diag_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Decoded diagnostic controls, fanned out to every EDP slice
interface diag_if;

  // One-cycle write pulse for AR
  logic load;

  // One-cycle increment pulse, also the carry into the low slice
  logic inc;

  // Slices put AR on the bus while high
  logic read_ar;

  // Write data registered with the strobe
  kl_ebus_pkg::ebus_word_u wdata;

  modport decoder (
    output load,
    output inc,
    output read_ar,
    output wdata
  );

  modport slice (
    input load,
    input inc,
    input read_ar,
    input wdata
  );

endinterface

`default_nettype wire

/* hdl/ebus_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kl_ebus_cfg.svh"

module ebus_mux (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [0:`KL_SLICES-1][0:`KL_SLICE_BITS-1] slice_field,
  input  logic [0:`KL_SLICES-1]                    slice_driving,
  input  kl_ebus_pkg::ebus_word_u                  ir,
  input  logic                                     ir_driving,
  output kl_ebus_pkg::ebus_word_u                  rdata,
  output logic                                     rd_valid
);

  kl_ebus_pkg::ebus_word_u bus;
  logic                    any_driving;

  assign any_driving = ir_driving || (|slice_driving);

  // IR wins, then the EDP group, each board filling its own field
  always_comb begin
    bus = '0;
    if (ir_driving) begin
      bus = ir;
    end else if (|slice_driving) begin
      for (int i = 0; i < `KL_SLICES; i++) begin
        bus.field[i] = slice_field[i];
      end
    end
  end

  // Read word held until the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      rdata    <= '0;
    end else begin
      rd_valid <= any_driving;
      if (any_driving) begin
        rdata <= bus;
      end
    end
  end

  a_one_driver: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ir_driving && (|slice_driving))
  ) else $error("IR and EDP drive the EBUS together");

  // All EDP boards read AR as a group
  a_slices_agree: assert property (
    @(posedge clk) disable iff (!rst_n)
    (slice_driving == '0) || (&slice_driving)
  ) else $error("EDP driving flags disagree: %b", slice_driving);

endmodule

`default_nettype wire

/* hdl/edp_slice.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kl_ebus_cfg.svh"

module edp_slice #(
  parameter int SLICE = 0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  diag_if.slice                      diag,
  input  logic                       carry_in,
  output logic                       carry_out,
  output logic [0:`KL_SLICE_BITS-1]  field,
  output logic                       driving
);

  logic [0:`KL_SLICE_BITS-1] ar;

  // Carry ripples toward bit 0 only through an all-ones slice
  assign carry_out = carry_in && (&ar);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar <= '0;
    end else if (diag.load) begin
      ar <= diag.wdata.field[SLICE];
    end else if (diag.inc) begin
      ar <= ar + `KL_SLICE_BITS'(carry_in);
    end
  end

  // Bus drive straight from AR while the read is selected
  assign driving = diag.read_ar;
  assign field   = diag.read_ar ? ar : '0;

  // The decoder never issues write and increment in the same cycle
  a_load_inc_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(diag.load && diag.inc)
  ) else $error("slice %0d sees load and inc together", SLICE);

endmodule

`default_nettype wire

/* hdl/kl_ebus_cfg.svh */
`ifndef KL_EBUS_CFG_SVH
`define KL_EBUS_CFG_SVH

// EBUS data word and AR width
`define KL_WORD_BITS 36

// Bits held by one EDP board
`define KL_SLICE_BITS 6

// EDP boards making up AR
`define KL_SLICES 6

// Diagnostic function code width
`define KL_DS_BITS 3

`endif

/* hdl/kl_ebus_pkg.sv */
`default_nettype none

`include "kl_ebus_cfg.svh"

package kl_ebus_pkg;

  // Diagnostic functions, codes 5 to 7 are ignored
  typedef enum logic [`KL_DS_BITS-1:0] {
    DS_WR_AR  = 3'd0,
    DS_RD_AR  = 3'd1,
    DS_INC_AR = 3'd2,
    DS_WR_IR  = 3'd3,
    DS_RD_IR  = 3'd4
  } ds_e;

  // One EBUS word in KL numbering, bit 0 is the most significant.
  // Seen either whole or as the six EDP fields, field 0 is bits 0 to 5
  typedef union packed {
    logic [0:`KL_WORD_BITS-1]                   word;
    logic [0:`KL_SLICES-1][0:`KL_SLICE_BITS-1] field;
  } ebus_word_u;

endpackage

`default_nettype wire

/* hdl/kl_ebus_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "kl_ebus_cfg.svh"

module kl_ebus_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     diag_strobe,
  input  logic [`KL_DS_BITS-1:0]   ds,
  input  logic [0:`KL_WORD_BITS-1] wdata,
  output logic [0:`KL_WORD_BITS-1] rdata,
  output logic                     rd_valid
);

  diag_if diag ();

  kl_ebus_pkg::ebus_word_u                  ir;
  logic                                     ir_driving;
  logic [0:`KL_SLICES-1][0:`KL_SLICE_BITS-1] slice_field;
  logic [0:`KL_SLICES-1]                    slice_driving;

  // carry[i + 1] feeds slice i, carry out of slice 0 is dropped
  logic [0:`KL_SLICES]                      carry;

  assign carry[`KL_SLICES] = diag.inc;

  diag_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .diag_strobe (diag_strobe),
    .ds          (kl_ebus_pkg::ds_e'(ds)),
    .wdata       (wdata),
    .diag        (diag.decoder),
    .ir          (ir),
    .ir_driving  (ir_driving)
  );

  // Six EDP boards, slice 5 holds the low bits
  for (genvar g = 0; g < `KL_SLICES; g++) begin : g_edp
    edp_slice #(
      .SLICE (g)
    ) u_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .diag      (diag.slice),
      .carry_in  (carry[g+1]),
      .carry_out (carry[g]),
      .field     (slice_field[g]),
      .driving   (slice_driving[g])
    );
  end

  ebus_mux u_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .slice_field   (slice_field),
    .slice_driving (slice_driving),
    .ir            (ir),
    .ir_driving    (ir_driving),
    .rdata         (rdata),
    .rd_valid      (rd_valid)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the EBUS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module tb_kl_ebus -Mdir obj_dir

out=$(./obj_dir/Vtb_kl_ebus)
echo "$out"
echo "$out" | grep -qF "Finished with no errors"
